/* hdl/rename_defs.svh */
/*
 * Sizing for the register rename stage.
 * Included by the package and by every RTL module that needs a width.
 */

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

//////////////////////////////////////////////////
// Rename group
//////////////////////////////////////////////////

// Instructions renamed per cycle
`define RENAME_WIDTH        2

//////////////////////////////////////////////////
// Register files
//////////////////////////////////////////////////

// 32 architectural integer registers
`define ARF_INT_INDEX_SIZE  5
`define PRF_INT_NUM         64
`define PRF_INT_INDEX_SIZE  6

// Free list pointer, one extra bit for wrap
`define FL_PTR_SIZE         7

//////////////////////////////////////////////////
// Checkpoints
//////////////////////////////////////////////////

`define RAT_CP_NUM          4
`define RAT_CP_INDEX_SIZE   2

`endif

/* hdl/rename_pkg.sv */
/*
 * Types shared by the rename stage and its testbench.
 * Ports carry requests, responses and retires as packed arrays, one per lane.
 */

`include "rename_defs.svh"

package rename_pkg;

  // One instruction entering rename
  typedef struct packed {
    logic                           valid;
    logic [`ARF_INT_INDEX_SIZE-1:0] rs1;
    logic [`ARF_INT_INDEX_SIZE-1:0] rs2;
    logic [`ARF_INT_INDEX_SIZE-1:0] rd;
  } rename_req_t;

  // Renamed operands for one lane
  typedef struct packed {
    logic [`PRF_INT_INDEX_SIZE-1:0] prs1;
    logic [`PRF_INT_INDEX_SIZE-1:0] prs2;
    logic [`PRF_INT_INDEX_SIZE-1:0] prd;
    logic [`PRF_INT_INDEX_SIZE-1:0] prev_rd;
    logic                           prev_rd_valid;
  } rename_rsp_t;

  // Physical register released at commit
  typedef struct packed {
    logic                           valid;
    logic [`PRF_INT_INDEX_SIZE-1:0] prf;
  } retire_t;

  // Checkpoint save and restore strobes
  typedef struct packed {
    logic                          check;
    logic [`RAT_CP_INDEX_SIZE-1:0] check_idx;
    logic                          recover;
    logic [`RAT_CP_INDEX_SIZE-1:0] recover_idx;
  } ckpt_ctrl_t;

endpackage

/* hdl/free_list.sv */
/*
 * Circular free list of physical registers.
 * Pops hand out entries from the head in order, retires push at the tail.
 * The head is saved per checkpoint so recovery returns unused registers.
 */

`include "rename_defs.svh"

module free_list (
  input  logic                                                clock,
  input  logic                                                arst_n,
  input  logic [`RENAME_WIDTH-1:0]                            pop,
  input  rename_pkg::retire_t [`RENAME_WIDTH-1:0]             retire,
  input  rename_pkg::ckpt_ctrl_t                              ckpt,
  output logic [`RENAME_WIDTH-1:0][`PRF_INT_INDEX_SIZE-1:0]   new_prd,
  output logic                                                allocatable
);

  localparam int PTR_W   = `FL_PTR_SIZE;
  localparam int PRF_W   = `PRF_INT_INDEX_SIZE;
  localparam int ARF_NUM = 1 << `ARF_INT_INDEX_SIZE;

  logic [PRF_W-1:0] entries [`PRF_INT_NUM];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] head_next;
  logic [PTR_W-1:0] tail_next;
  logic [PTR_W-1:0] count;
  logic [PTR_W-1:0] head_cp [`RAT_CP_NUM];

  logic [`RENAME_WIDTH-1:0][PTR_W-1:0] rd_ptr;
  logic [`RENAME_WIDTH-1:0][PTR_W-1:0] wr_ptr;

  //////////////////////////////////////////////////
  // Pointer arithmetic
  //////////////////////////////////////////////////

  // Each lane reads past the pops of the lanes before it
  always_comb begin
    head_next = head;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      rd_ptr[i]  = head_next;
      head_next  = head_next + PTR_W'(pop[i]);
      new_prd[i] = entries[rd_ptr[i][PRF_W-1:0]];
    end
  end

  // Valid retires are packed at the tail, lane 0 first
  always_comb begin
    tail_next = tail;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      wr_ptr[i] = tail_next;
      tail_next = tail_next + PTR_W'(retire[i].valid);
    end
  end

  assign count       = tail - head;
  assign allocatable = count >= PTR_W'(`RENAME_WIDTH);

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  // Free at reset: physical 32..63, everything above the identity map
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head <= PTR_W'(ARF_NUM);
      tail <= PTR_W'(`PRF_INT_NUM);
    end else begin
      head <= ckpt.recover ? head_cp[ckpt.recover_idx] : head_next;
      tail <= tail_next;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `PRF_INT_NUM; i++) begin
        entries[i] <= PRF_W'(i);
      end
    end else begin
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        if (retire[i].valid) begin
          entries[wr_ptr[i][PRF_W-1:0]] <= retire[i].prf;
        end
      end
    end
  end

  // Saved head includes this cycle's pops
  always_ff @(posedge clock) begin
    if (ckpt.check) begin
      head_cp[ckpt.check_idx] <= head_next;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Physical 0 is never allocated, so at most 63 can be free
  count_bound: assert property (@(posedge clock) disable iff (!arst_n)
    count <= PTR_W'(`PRF_INT_NUM - 1));

  for (genvar g = 0; g < `RENAME_WIDTH; g++) begin : g_retire_chk
    no_push_zero: assert property (@(posedge clock) disable iff (!arst_n)
      retire[g].valid |-> retire[g].prf != '0);
  end

endmodule

/* hdl/mapping_table.sv */
/*
 * Architectural to physical register map for the integer file.
 * Renames a group of lanes per cycle with bypass between lanes and keeps
 * checkpoint copies of the table for recovery.
 */

`include "rename_defs.svh"

module mapping_table (
  input  logic                                                clock,
  input  logic                                                arst_n,
  input  rename_pkg::rename_req_t [`RENAME_WIDTH-1:0]         req,
  input  rename_pkg::ckpt_ctrl_t                              ckpt,
  input  logic [`RENAME_WIDTH-1:0][`PRF_INT_INDEX_SIZE-1:0]   new_prd,
  input  logic                                                allocatable,
  output logic [`RENAME_WIDTH-1:0]                            pop,
  output rename_pkg::rename_rsp_t [`RENAME_WIDTH-1:0]         rsp
);

  localparam int ARF_W   = `ARF_INT_INDEX_SIZE;
  localparam int PRF_W   = `PRF_INT_INDEX_SIZE;
  localparam int ARF_NUM = 1 << `ARF_INT_INDEX_SIZE;

  logic [PRF_W-1:0] rat      [ARF_NUM];
  logic [PRF_W-1:0] rat_next [ARF_NUM];
  logic [PRF_W-1:0] rat_cp   [`RAT_CP_NUM][ARF_NUM];

  //////////////////////////////////////////////////
  // Lookup with bypass
  //////////////////////////////////////////////////

  // Table read, overridden by any earlier lane writing the same register
  function automatic logic [PRF_W-1:0] lookup(
    input logic [ARF_W-1:0] arch,
    input int               lane
  );
    logic [PRF_W-1:0] phys;
    phys = rat[arch];
    for (int j = 0; j < lane; j++) begin
      if (pop[j] && req[j].rd == arch) begin
        phys = new_prd[j];
      end
    end
    // x0 never renamed
    if (arch == '0) begin
      phys = '0;
    end
    return phys;
  endfunction

  // A lane allocates only for a real destination, and not during recovery
  always_comb begin
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      pop[i] = req[i].valid && (req[i].rd != '0) && !ckpt.recover;
    end
  end

  always_comb begin
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      rsp[i].prs1          = lookup(req[i].rs1, i);
      rsp[i].prs2          = lookup(req[i].rs2, i);
      rsp[i].prd           = pop[i] ? new_prd[i] : '0;
      rsp[i].prev_rd       = lookup(req[i].rd, i);
      rsp[i].prev_rd_valid = pop[i];
    end
  end

  //////////////////////////////////////////////////
  // Table update
  //////////////////////////////////////////////////

  // Later lanes win on equal destinations
  always_comb begin
    rat_next = rat;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (pop[i]) begin
        rat_next[req[i].rd] = new_prd[i];
      end
    end
  end

  // Identity map out of reset
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int a = 0; a < ARF_NUM; a++) begin
        rat[a] <= PRF_W'(a);
      end
    end else if (ckpt.recover) begin
      rat <= rat_cp[ckpt.recover_idx];
    end else begin
      rat <= rat_next;
    end
  end

  // Snapshot as it stands after this cycle's renames
  always_ff @(posedge clock) begin
    if (ckpt.check) begin
      rat_cp[ckpt.check_idx] <= rat_next;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Allocation must stay within what the free list can give
  pop_needs_room: assert property (@(posedge clock) disable iff (!arst_n)
    |pop |-> allocatable);

  ckpt_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
    !(ckpt.check && ckpt.recover));

endmodule

/* hdl/rename_unit.sv */
/*
 * Register rename stage top level.
 * Renames RENAME_WIDTH instructions per cycle; requests are only
 * presented while allocatable is high.
 */

`include "rename_defs.svh"

module rename_unit (
  input  logic                                         clock,
  input  logic                                         arst_n,
  input  rename_pkg::rename_req_t [`RENAME_WIDTH-1:0]  req,
  input  rename_pkg::retire_t [`RENAME_WIDTH-1:0]      retire,
  input  rename_pkg::ckpt_ctrl_t                       ckpt,
  output rename_pkg::rename_rsp_t [`RENAME_WIDTH-1:0]  rsp,
  output logic                                         allocatable
);

  // Allocation handshake between map and free list
  logic [`RENAME_WIDTH-1:0]                          pop;
  logic [`RENAME_WIDTH-1:0][`PRF_INT_INDEX_SIZE-1:0] new_prd;

  //////////////////////////////////////////////////
  // Map
  //////////////////////////////////////////////////

  mapping_table u_map (
    .clock       (clock      ),
    .arst_n      (arst_n     ),
    .req         (req        ),
    .ckpt        (ckpt       ),
    .new_prd     (new_prd    ),
    .allocatable (allocatable),
    .pop         (pop        ),
    .rsp         (rsp        )
  );

  //////////////////////////////////////////////////
  // Free physical registers
  //////////////////////////////////////////////////

  free_list u_free (
    .clock       (clock      ),
    .arst_n      (arst_n     ),
    .pop         (pop        ),
    .retire      (retire     ),
    .ckpt        (ckpt       ),
    .new_prd     (new_prd    ),
    .allocatable (allocatable)
  );

endmodule

/* tests/rename_tb.sv */
/*
 * Testbench for the rename stage. Drives two-lane renames, retires and
 * checkpoint strobes on the falling edge, keeps a reference map and free
 * FIFO, and lets concurrent assertions compare every response with it.
 */

`include "rename_defs.svh"

module rename_tb;

  localparam int ARF_W      = `ARF_INT_INDEX_SIZE;
  localparam int PRF_W      = `PRF_INT_INDEX_SIZE;
  localparam int ARF_NUM    = 1 << `ARF_INT_INDEX_SIZE;
  localparam int MAX_CYCLES = 1000;

  logic                                           clock = 1'b0;
  logic                                           arst_n;
  rename_pkg::rename_req_t [`RENAME_WIDTH-1:0]    req;
  rename_pkg::retire_t [`RENAME_WIDTH-1:0]        retire;
  rename_pkg::ckpt_ctrl_t                         ckpt;
  rename_pkg::rename_rsp_t [`RENAME_WIDTH-1:0]    rsp;
  logic                                           allocatable;

  // Reference model state
  logic [PRF_W-1:0]                               ref_map [ARF_NUM];
  logic [PRF_W-1:0]                               free_q [$];
  int                                             head;
  logic [PRF_W-1:0]                               cp_map [`RAT_CP_NUM][ARF_NUM];
  int                                             cp_head [`RAT_CP_NUM];

  // Expected outputs for the cycle being driven
  rename_pkg::rename_rsp_t [`RENAME_WIDTH-1:0]    exp_rsp;
  rename_pkg::rename_rsp_t [`RENAME_WIDTH-1:0]    last_rsp;
  logic [`RENAME_WIDTH-1:0]                       exp_pop;
  logic                                           exp_alloc;
  int                                             cycle_count = 0;

  rename_unit u_dut (
    .clock       (clock      ),
    .arst_n      (arst_n     ),
    .req         (req        ),
    .retire      (retire     ),
    .ckpt        (ckpt       ),
    .rsp         (rsp        ),
    .allocatable (allocatable)
  );

  always #10 clock = ~clock;

  task automatic stop_failing(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      stop_failing("Timeout: the run went past its cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  for (genvar g = 0; g < `RENAME_WIDTH; g++) begin : g_rsp_chk
    rsp_matches: assert property (@(posedge clock) disable iff (!arst_n)
      rsp[g] == exp_rsp[g])
      else stop_failing($sformatf("CHECK FAILED at time %0t: lane %0d response differs",
                                  $time, g));
  end

  alloc_matches: assert property (@(posedge clock) disable iff (!arst_n)
    allocatable == exp_alloc)
    else stop_failing($sformatf("CHECK FAILED at time %0t: allocatable differs", $time));

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  task automatic reset_model();
    for (int a = 0; a < ARF_NUM; a++) begin
      ref_map[a] = PRF_W'(a);
    end
    free_q.delete();
    for (int p = ARF_NUM; p < `PRF_INT_NUM; p++) begin
      free_q.push_back(PRF_W'(p));
    end
    head = 0;
  endtask

  // Nearest earlier lane writing the register wins over the map
  function automatic logic [PRF_W-1:0] source_map(input logic [ARF_W-1:0] arch, input int lane);
    if (arch == '0) begin
      return '0;
    end
    for (int j = lane - 1; j >= 0; j--) begin
      if (exp_pop[j] && req[j].rd == arch) begin
        return exp_rsp[j].prd;
      end
    end
    return ref_map[arch];
  endfunction

  task automatic predict_response();
    int h;
    h = head;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      exp_pop[i]               = req[i].valid && req[i].rd != '0 && !ckpt.recover;
      exp_rsp[i].prs1          = source_map(req[i].rs1, i);
      exp_rsp[i].prs2          = source_map(req[i].rs2, i);
      exp_rsp[i].prev_rd       = source_map(req[i].rd, i);
      exp_rsp[i].prev_rd_valid = exp_pop[i];
      exp_rsp[i].prd           = exp_pop[i] ? free_q[h] : '0;
      if (exp_pop[i]) begin
        h++;
      end
    end
    exp_alloc = (free_q.size() - head) >= `RENAME_WIDTH;
  endtask

  task automatic commit_model();
    if (ckpt.recover) begin
      ref_map = cp_map[ckpt.recover_idx];
      head    = cp_head[ckpt.recover_idx];
    end else begin
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        if (exp_pop[i]) begin
          ref_map[req[i].rd] = exp_rsp[i].prd;
          head++;
        end
      end
    end
    // Snapshot after this cycle's renames
    if (ckpt.check) begin
      cp_map[ckpt.check_idx]  = ref_map;
      cp_head[ckpt.check_idx] = head;
    end
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (retire[i].valid) begin
        free_q.push_back(retire[i].prf);
      end
    end
    last_rsp = exp_rsp;
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [ARF_W-1:0] rand_arch(input int lo);
    return ARF_W'($urandom_range(ARF_NUM - 1, lo));
  endfunction

  function automatic rename_pkg::rename_req_t make_req(input logic [ARF_W-1:0] rs1,
      input logic [ARF_W-1:0] rs2, input logic [ARF_W-1:0] rd);
    rename_pkg::rename_req_t r;
    r.valid = 1'b1;
    r.rs1   = rs1;
    r.rs2   = rs2;
    r.rd    = rd;
    return r;
  endfunction

  function automatic rename_pkg::rename_req_t rand_req(input int rd_lo);
    return make_req(rand_arch(0), rand_arch(0), rand_arch(rd_lo));
  endfunction

  // Free whatever the previous cycle displaced
  function automatic rename_pkg::retire_t [`RENAME_WIDTH-1:0] prev_as_retire();
    rename_pkg::retire_t [`RENAME_WIDTH-1:0] t;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      t[i].valid = last_rsp[i].prev_rd_valid;
      t[i].prf   = last_rsp[i].prev_rd;
    end
    return t;
  endfunction

  function automatic rename_pkg::ckpt_ctrl_t ckpt_cmd(input logic check, input logic recover,
      input logic [`RAT_CP_INDEX_SIZE-1:0] idx);
    rename_pkg::ckpt_ctrl_t c;
    c.check       = check;
    c.check_idx   = idx;
    c.recover     = recover;
    c.recover_idx = idx;
    return c;
  endfunction

  // Called on a falling edge, returns on the next one
  task automatic drive_cycle(input rename_pkg::rename_req_t r0, input rename_pkg::rename_req_t r1,
      input rename_pkg::retire_t [`RENAME_WIDTH-1:0] t, input rename_pkg::ckpt_ctrl_t c);
    req[0] = r0;
    req[1] = r1;
    retire = t;
    ckpt   = c;
    predict_response();
    @(posedge clock);
    commit_model();
    @(negedge clock);
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    req    = '0;
    retire = '0;
    ckpt   = '0;
    reset_model();
    repeat (2) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h1650));
    arst_n   = 1'b1;
    req      = '0;
    retire   = '0;
    ckpt     = '0;
    last_rsp = '0;
    #1;
    apply_reset();

    // Identity map straight out of reset
    repeat (4) drive_cycle(make_req(rand_arch(0), rand_arch(0), '0),
                           make_req(rand_arch(0), rand_arch(0), '0), '0, '0);

    // Random renames, displaced registers go back each cycle
    repeat (120) drive_cycle(rand_req(0), rand_req(0), prev_as_retire(), '0);

    // Lane 1 sees lane 0's destination
    drive_cycle(make_req(5'd3, 5'd4, 5'd5), make_req(5'd5, 5'd5, 5'd5), prev_as_retire(), '0);
    drive_cycle(make_req(5'd5, 5'd1, 5'd7), make_req(5'd7, 5'd2, 5'd9), prev_as_retire(), '0);

    // x0 as destination allocates nothing
    drive_cycle(make_req(5'd0, 5'd6, 5'd0), make_req(5'd0, 5'd9, 5'd0), '0, '0);
    drive_cycle(make_req(5'd0, 5'd0, 5'd0), make_req(5'd9, 5'd0, 5'd11), '0, '0);

    // Two checkpoints, rewind to the newer one, then the older one
    drive_cycle(make_req(rand_arch(0), rand_arch(0), '0), '0, '0, ckpt_cmd(1'b1, 1'b0, 2'd1));
    repeat (3) drive_cycle(rand_req(1), rand_req(0), '0, '0);
    drive_cycle(rand_req(1), rand_req(1), '0, ckpt_cmd(1'b1, 1'b0, 2'd2));
    repeat (4) drive_cycle(rand_req(1), rand_req(0), '0, '0);
    drive_cycle(rand_req(1), rand_req(1), '0, ckpt_cmd(1'b0, 1'b1, 2'd2));
    repeat (3) drive_cycle(rand_req(1), rand_req(1), '0, '0);
    drive_cycle(rand_req(1), rand_req(1), prev_as_retire(), ckpt_cmd(1'b0, 1'b1, 2'd1));
    repeat (4) drive_cycle(rand_req(0), rand_req(1), '0, '0);

    // Drain the free list, then refill it by two
    apply_reset();
    repeat (16) drive_cycle(rand_req(1), rand_req(1), '0, '0);
    drive_cycle('0, '0, prev_as_retire(), '0);
    drive_cycle('0, '0, '0, '0);
    drive_cycle(rand_req(1), rand_req(1), '0, '0);
    drive_cycle('0, '0, '0, '0);

    $display("TEST OK");
    $finish;
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/mapping_table.sv
hdl/rename_unit.sv
tests/rename_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rename stage testbench with Verilator.
# Passes only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module rename_tb -o rename_sim \
  && ./obj_dir/rename_sim | tee /dev/stderr | grep -qx "TEST OK" \
  && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }
